// File: files.f
issue_pkg.sv
reservation_station.sv
add_unit.sv
multiply_unit.sv
cdb_arbiter.sv
issue_core.sv
issue_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= issue_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: issue_tb.sv
`timescale 1ns/100ps

module issue_tb;

    logic               clk;
    logic               rst;
    logic               dispatch_valid;
    logic               dispatch_ready;
    issue_pkg::alu_op_t dispatch_op;
    issue_pkg::tag_t    src1_tag;
    logic               src1_ready;
    issue_pkg::data_t   src1_value;
    issue_pkg::tag_t    src2_tag;
    logic               src2_ready;
    issue_pkg::data_t   src2_value;
    issue_pkg::tag_t    dest_tag;
    issue_pkg::rob_id_t rob_id;
    logic               cdb_valid;
    issue_pkg::tag_t    cdb_tag;
    issue_pkg::data_t   cdb_value;
    issue_pkg::rob_id_t cdb_rob;

    logic [31:0]        lfsr;
    int                 errors;
    int                 checks;
    int                 dispatched;
    int                 completed;
    int                 outstanding;
    issue_pkg::rob_id_t next_rob;
    issue_pkg::tag_t    next_tag;
    issue_pkg::tag_t    last_tag;                   // dest of the latest dispatch
    issue_pkg::data_t   tag_value [64];             // model value per physical tag
    logic               tag_known [64];             // value already seen on the cdb
    logic               tag_busy [64];
    issue_pkg::data_t   exp_value [32];
    issue_pkg::tag_t    exp_tag [32];
    logic               pending [32];

    issue_core dut0 (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};   // taps 32,22,2,1
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic issue_pkg::alu_op_t rand_op();
        logic [1:0] v;
        v = 2'(rand_bits(2));
        case (v)
            2'd0:    return issue_pkg::ALU_ADD;
            2'd2:    return issue_pkg::ALU_MUL;
            default: return issue_pkg::ALU_SUB;
        endcase
    endfunction

    function automatic issue_pkg::data_t alu_model(input issue_pkg::alu_op_t op,
                                                   input issue_pkg::data_t a,
                                                   input issue_pkg::data_t b);
        case (op)
            issue_pkg::ALU_SUB: return a - b;
            issue_pkg::ALU_MUL: return a * b;       // low 32 bits of the product
            default:            return a + b;
        endcase
    endfunction

    // round robin over free tags, so the previous dest is never handed out again
    function automatic issue_pkg::tag_t alloc_tag();
        issue_pkg::tag_t t;
        for (int i = 0; i < 64 && tag_busy[next_tag]; i++)
            next_tag++;
        t = next_tag;
        next_tag++;
        tag_busy[t] = 1'b1;
        tag_known[t] = 1'b0;
        return t;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // entered at a drive point, returns at the drive point after the transfer
    task automatic send(input issue_pkg::alu_op_t op, input logic dep1, input issue_pkg::tag_t t1,
                        input logic dep2, input issue_pkg::tag_t t2, input issue_pkg::tag_t dest,
                        input issue_pkg::data_t ra, input issue_pkg::data_t rb);
        issue_pkg::data_t a;
        issue_pkg::data_t b;
        logic             accepted;
        int               n;
        a = dep1 ? tag_value[t1] : ra;
        b = dep2 ? tag_value[t2] : rb;
        tag_value[dest] = alu_model(op, a, b);
        accepted = 1'b0;
        n = 0;
        while (!accepted && n < 200)
        begin
            dispatch_valid = 1'b1;
            dispatch_op = op;
            src1_tag = t1;
            src1_ready = !dep1 || tag_known[t1];    // refreshed every retry
            src1_value = src1_ready ? a : ~a;       // junk while the producer is pending
            src2_tag = t2;
            src2_ready = !dep2 || tag_known[t2];
            src2_value = src2_ready ? b : ~b;
            dest_tag = dest;
            rob_id = next_rob;
            @(negedge clk);
            accepted = dispatch_ready;
            @(posedge clk);
            #1;
            n++;
        end
        dispatch_valid = 1'b0;
        if (accepted)
        begin
            exp_value[next_rob] = tag_value[dest];
            exp_tag[next_rob] = dest;
            pending[next_rob] = 1'b1;
            next_rob++;
            dispatched++;
            outstanding++;
            last_tag = dest;
        end
        else
        begin
            $display("Dispatch of rob %0d was not accepted in time", next_rob);
            errors++;
        end
    endtask

    task automatic send_random(input logic dep1, input logic dep2);
        issue_pkg::alu_op_t op;
        issue_pkg::data_t   ra;
        issue_pkg::data_t   rb;
        op = rand_op();
        ra = rand_bits(32);
        rb = rand_bits(32);
        send(op, dep1, last_tag, dep2, last_tag, alloc_tag(), ra, rb);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (outstanding > 0 && n < 200)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (outstanding > 0)
        begin
            $display("Timeout with %0d operations never completed", outstanding);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    // retirement side, sampled mid-cycle
    always @(negedge clk)
    begin
        if (!rst && cdb_valid === 1'b1)
        begin
            if (!pending[cdb_rob])
            begin
                $display("Completion seen for rob %0d, which is not outstanding", cdb_rob);
                errors++;
            end
            else
            begin
                check("cdb_value", cdb_value, exp_value[cdb_rob]);
                check("cdb_tag", 32'(cdb_tag), 32'(exp_tag[cdb_rob]));
                pending[cdb_rob] = 1'b0;
                tag_busy[exp_tag[cdb_rob]] = 1'b0;
                tag_known[exp_tag[cdb_rob]] = 1'b1;
                completed++;
                outstanding--;
            end
        end
    end

    initial
    begin
        int                 err0;
        issue_pkg::tag_t    hold_tag;
        issue_pkg::data_t   ma;
        issue_pkg::data_t   mb;
        issue_pkg::alu_op_t op_k;
        clk = 1'b0;
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op = issue_pkg::ALU_ADD;
        src1_tag = '0;
        src1_ready = 1'b0;
        src1_value = '0;
        src2_tag = '0;
        src2_ready = 1'b0;
        src2_value = '0;
        dest_tag = '0;
        rob_id = '0;
        lfsr = 32'h66fb45a9;
        errors = 0;
        checks = 0;
        dispatched = 0;
        completed = 0;
        outstanding = 0;
        next_rob = '0;
        next_tag = '0;
        last_tag = '0;
        for (int i = 0; i < 64; i++)
        begin
            tag_value[i] = '0;
            tag_known[i] = 1'b1;
            tag_busy[i] = 1'b0;
        end
        for (int i = 0; i < 32; i++)
        begin
            pending[i] = 1'b0;
            exp_value[i] = '0;
            exp_tag[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        err0 = errors;
        check("cdb_valid", 32'(cdb_valid), 32'd0);
        for (int k = 0; k < 3; k++)
        begin
            dispatch_op = issue_pkg::alu_op_t'(2'(k));
            #1;
            check("dispatch_ready", 32'(dispatch_ready), 32'd1);
        end
        idle(1);
        finish_test("reset state", err0);

        err0 = errors;
        repeat (24) send_random(1'b0, 1'b0);
        drain();
        finish_test("independent ops", err0);

        err0 = errors;
        repeat (16)
        begin
            send_random(1'b1, rand_bits(1) != 0);
            idle(int'(rand_bits(2)));               // gap of 1 lands on the forwarding path
        end
        drain();
        finish_test("dependent chains", err0);

        err0 = errors;
        hold_tag = alloc_tag();                     // producer dispatched last
        ma = rand_bits(32);
        mb = rand_bits(32);
        tag_value[hold_tag] = alu_model(issue_pkg::ALU_MUL, ma, mb);
        for (int k = 0; k < issue_pkg::ADD_RS_DEPTH; k++)
        begin
            op_k = (rand_bits(1) != 0) ? issue_pkg::ALU_SUB : issue_pkg::ALU_ADD;
            send(op_k, 1'b1, hold_tag, 1'b0, '0, alloc_tag(), '0, rand_bits(32));
        end
        dispatch_op = issue_pkg::ALU_ADD;
        @(negedge clk);
        check("dispatch_ready", 32'(dispatch_ready), 32'd0);
        @(posedge clk);
        #1;
        send(issue_pkg::ALU_MUL, 1'b0, '0, 1'b0, '0, hold_tag, ma, mb);
        drain();
        finish_test("station capacity", err0);

        err0 = errors;
        for (int burst = 0; burst < 4; burst++)
        begin
            repeat (12) send_random(rand_bits(2) == 0, 1'b0);
            drain();
        end
        check("completions", 32'(completed), 32'(dispatched));
        finish_test("mixed bursts", err0);

        $display("checks %0d, errors %0d, dispatched %0d, completed %0d",
                 checks, errors, dispatched, completed);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: issue_core.sv
`timescale 1ns/100ps

module issue_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    output logic                dispatch_ready,
    input  issue_pkg::alu_op_t  dispatch_op,
    input  issue_pkg::tag_t     src1_tag,
    input  logic                src1_ready,
    input  issue_pkg::data_t    src1_value,
    input  issue_pkg::tag_t     src2_tag,
    input  logic                src2_ready,
    input  issue_pkg::data_t    src2_value,
    input  issue_pkg::tag_t     dest_tag,
    input  issue_pkg::rob_id_t  rob_id,
    output logic                cdb_valid,
    output issue_pkg::tag_t     cdb_tag,
    output issue_pkg::data_t    cdb_value,
    output issue_pkg::rob_id_t  cdb_rob
);

    logic               is_mul;
    logic               add_in_ready, mul_in_ready;
    logic               add_issue_valid, add_issue_ready, mul_issue_valid, mul_issue_ready;
    issue_pkg::alu_op_t add_issue_op, mul_issue_op;
    issue_pkg::data_t   add_issue_a, add_issue_b, mul_issue_a, mul_issue_b;
    issue_pkg::tag_t    add_issue_tag, mul_issue_tag;
    issue_pkg::rob_id_t add_issue_rob, mul_issue_rob;
    logic               add_res_valid, add_res_ready, mul_res_valid, mul_res_ready;
    issue_pkg::tag_t    add_res_tag, mul_res_tag;
    issue_pkg::data_t   add_res_value, mul_res_value;
    issue_pkg::rob_id_t add_res_rob, mul_res_rob;

    assign is_mul = (dispatch_op == issue_pkg::ALU_MUL);
    assign dispatch_ready = is_mul ? mul_in_ready : add_in_ready;

    reservation_station #(.DEPTH(issue_pkg::ADD_RS_DEPTH)) add_rs (
        .clk(clk), .rst(rst),
        .in_valid(dispatch_valid && !is_mul), .in_ready(add_in_ready), .in_op(dispatch_op),
        .in_src1_tag(src1_tag), .in_src2_tag(src2_tag),
        .in_src1_ready(src1_ready), .in_src2_ready(src2_ready),
        .in_src1_value(src1_value), .in_src2_value(src2_value),
        .in_dest_tag(dest_tag), .in_rob(rob_id),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .issue_valid(add_issue_valid), .issue_ready(add_issue_ready), .issue_op(add_issue_op),
        .issue_a(add_issue_a), .issue_b(add_issue_b),
        .issue_tag(add_issue_tag), .issue_rob(add_issue_rob)
    );

    reservation_station #(.DEPTH(issue_pkg::MUL_RS_DEPTH)) mul_rs (
        .clk(clk), .rst(rst),
        .in_valid(dispatch_valid && is_mul), .in_ready(mul_in_ready), .in_op(dispatch_op),
        .in_src1_tag(src1_tag), .in_src2_tag(src2_tag),
        .in_src1_ready(src1_ready), .in_src2_ready(src2_ready),
        .in_src1_value(src1_value), .in_src2_value(src2_value),
        .in_dest_tag(dest_tag), .in_rob(rob_id),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .issue_valid(mul_issue_valid), .issue_ready(mul_issue_ready), .issue_op(mul_issue_op),
        .issue_a(mul_issue_a), .issue_b(mul_issue_b),
        .issue_tag(mul_issue_tag), .issue_rob(mul_issue_rob)
    );

    add_unit add_unit0 (
        .clk(clk), .rst(rst),
        .issue_valid(add_issue_valid), .issue_ready(add_issue_ready), .issue_op(add_issue_op),
        .issue_a(add_issue_a), .issue_b(add_issue_b),
        .issue_tag(add_issue_tag), .issue_rob(add_issue_rob),
        .res_valid(add_res_valid), .res_ready(add_res_ready),
        .res_tag(add_res_tag), .res_value(add_res_value), .res_rob(add_res_rob)
    );

    multiply_unit mul_unit0 (
        .clk(clk), .rst(rst),
        .issue_valid(mul_issue_valid), .issue_ready(mul_issue_ready),
        .issue_a(mul_issue_a), .issue_b(mul_issue_b),
        .issue_tag(mul_issue_tag), .issue_rob(mul_issue_rob),
        .res_valid(mul_res_valid), .res_ready(mul_res_ready),
        .res_tag(mul_res_tag), .res_value(mul_res_value), .res_rob(mul_res_rob)
    );

    cdb_arbiter cdb_arbiter0 (
        .clk(clk), .rst(rst),
        .mul_valid(mul_res_valid), .mul_ready(mul_res_ready),
        .mul_tag(mul_res_tag), .mul_value(mul_res_value), .mul_rob(mul_res_rob),
        .add_valid(add_res_valid), .add_ready(add_res_ready),
        .add_tag(add_res_tag), .add_value(add_res_value), .add_rob(add_res_rob),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value), .cdb_rob(cdb_rob)
    );

    // steering must keep adds out of the multiply station
    a_mul_route: assert property (@(posedge clk) disable iff (rst)
        mul_issue_valid |-> mul_issue_op == issue_pkg::ALU_MUL);

endmodule

// File: cdb_arbiter.sv
`timescale 1ns/100ps

module cdb_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                mul_valid,
    output logic                mul_ready,
    input  issue_pkg::tag_t     mul_tag,
    input  issue_pkg::data_t    mul_value,
    input  issue_pkg::rob_id_t  mul_rob,
    input  logic                add_valid,
    output logic                add_ready,
    input  issue_pkg::tag_t     add_tag,
    input  issue_pkg::data_t    add_value,
    input  issue_pkg::rob_id_t  add_rob,
    output logic                cdb_valid,
    output issue_pkg::tag_t     cdb_tag,
    output issue_pkg::data_t    cdb_value,
    output issue_pkg::rob_id_t  cdb_rob
);

    // multiplier has fixed priority, its pipe stalls as a whole
    assign mul_ready = mul_valid;
    assign add_ready = add_valid && !mul_valid;

    assign cdb_valid = mul_valid || add_valid;
    assign cdb_tag   = mul_valid ? mul_tag : add_tag;
    assign cdb_value = mul_valid ? mul_value : add_value;
    assign cdb_rob   = mul_valid ? mul_rob : add_rob;

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        !(mul_ready && add_ready));
    a_grant_bus: assert property (@(posedge clk) disable iff (rst)
        cdb_valid == (mul_ready || add_ready));

endmodule

// File: multiply_unit.sv
`timescale 1ns/100ps

module multiply_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid,
    output logic                issue_ready,
    input  issue_pkg::data_t    issue_a,
    input  issue_pkg::data_t    issue_b,
    input  issue_pkg::tag_t     issue_tag,
    input  issue_pkg::rob_id_t  issue_rob,
    output logic                res_valid,
    input  logic                res_ready,
    output issue_pkg::tag_t     res_tag,
    output issue_pkg::data_t    res_value,
    output issue_pkg::rob_id_t  res_rob
);

    logic [issue_pkg::MUL_STAGES-1:0] stage_valid;
    issue_pkg::tag_t    stage_tag [issue_pkg::MUL_STAGES];
    issue_pkg::rob_id_t stage_rob [issue_pkg::MUL_STAGES];
    issue_pkg::data_t   stage_value [issue_pkg::MUL_STAGES];
    logic [15:0]        cross_lo;               // low half of a[15:0] * b[31:16]
    logic               advance;

    assign advance     = !stage_valid[issue_pkg::MUL_STAGES-1] || res_ready;
    assign issue_ready = advance;

    assign res_valid = stage_valid[issue_pkg::MUL_STAGES-1];
    assign res_tag   = stage_tag[issue_pkg::MUL_STAGES-1];
    assign res_value = stage_value[issue_pkg::MUL_STAGES-1];
    assign res_rob   = stage_rob[issue_pkg::MUL_STAGES-1];

    always_ff @(posedge clk)
    begin
        if (rst)
            stage_valid <= '0;
        else if (advance)
            stage_valid <= {stage_valid[issue_pkg::MUL_STAGES-2:0], issue_valid};
    end

    // whole pipe moves together or not at all
    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            stage_tag[0]   <= issue_tag;
            stage_rob[0]   <= issue_rob;
            stage_value[0] <= issue_a * {16'h0000, issue_b[15:0]};
            cross_lo       <= issue_a[15:0] * issue_b[31:16];
            stage_value[1] <= stage_value[0] + {cross_lo, 16'h0000};   // wraps to 32 bits
            for (int k = 1; k < issue_pkg::MUL_STAGES; k++)
            begin
                stage_tag[k] <= stage_tag[k-1];
                stage_rob[k] <= stage_rob[k-1];
            end
            for (int k = 2; k < issue_pkg::MUL_STAGES; k++)
            begin
                stage_value[k] <= stage_value[k-1];
            end
        end
    end

    a_res_hold: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_value) &&
                                    $stable(res_tag) && $stable(res_rob));

endmodule

// File: add_unit.sv
`timescale 1ns/100ps

module add_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid,
    output logic                issue_ready,
    input  issue_pkg::alu_op_t  issue_op,
    input  issue_pkg::data_t    issue_a,
    input  issue_pkg::data_t    issue_b,
    input  issue_pkg::tag_t     issue_tag,
    input  issue_pkg::rob_id_t  issue_rob,
    output logic                res_valid,
    input  logic                res_ready,
    output issue_pkg::tag_t     res_tag,
    output issue_pkg::data_t    res_value,
    output issue_pkg::rob_id_t  res_rob
);

    // register is free, or drains in the same cycle
    assign issue_ready = !res_valid || res_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
            res_valid <= 1'b0;
        else if (issue_ready)
            res_valid <= issue_valid;
    end

    always_ff @(posedge clk)
    begin
        if (issue_valid && issue_ready)
        begin
            res_tag   <= issue_tag;
            res_rob   <= issue_rob;
            res_value <= (issue_op == issue_pkg::ALU_SUB) ? issue_a - issue_b
                                                          : issue_a + issue_b;
        end
    end

endmodule

// File: reservation_station.sv
`timescale 1ns/100ps

module reservation_station #(
    parameter int DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  issue_pkg::alu_op_t  in_op,
    input  issue_pkg::tag_t     in_src1_tag,
    input  issue_pkg::tag_t     in_src2_tag,
    input  logic                in_src1_ready,
    input  logic                in_src2_ready,
    input  issue_pkg::data_t    in_src1_value,
    input  issue_pkg::data_t    in_src2_value,
    input  issue_pkg::tag_t     in_dest_tag,
    input  issue_pkg::rob_id_t  in_rob,
    input  logic                cdb_valid,
    input  issue_pkg::tag_t     cdb_tag,
    input  issue_pkg::data_t    cdb_value,
    output logic                issue_valid,
    input  logic                issue_ready,
    output issue_pkg::alu_op_t  issue_op,
    output issue_pkg::data_t    issue_a,
    output issue_pkg::data_t    issue_b,
    output issue_pkg::tag_t     issue_tag,
    output issue_pkg::rob_id_t  issue_rob
);

    issue_pkg::rs_state_t state [DEPTH];
    issue_pkg::alu_op_t   op [DEPTH];
    issue_pkg::tag_t      src1_tag [DEPTH];
    issue_pkg::tag_t      src2_tag [DEPTH];
    logic                 src1_ready [DEPTH];
    logic                 src2_ready [DEPTH];
    issue_pkg::data_t     src1_value [DEPTH];
    issue_pkg::data_t     src2_value [DEPTH];
    issue_pkg::tag_t      dest_tag [DEPTH];
    issue_pkg::rob_id_t   rob [DEPTH];

    logic [DEPTH-1:0]     wake1;                // cdb hits a missing source
    logic [DEPTH-1:0]     wake2;
    logic [DEPTH-1:0]     empty_vec;
    logic [DEPTH-1:0]     free_sel;             // one-hot, lowest empty entry
    logic [DEPTH-1:0]     issue_sel;            // one-hot, lowest ready entry
    logic                 in_fire;
    logic                 issue_fire;
    logic                 fwd1;
    logic                 fwd2;

    // a dispatch may name the tag that is on the bus right now
    assign fwd1 = !in_src1_ready && cdb_valid && (cdb_tag == in_src1_tag);
    assign fwd2 = !in_src2_ready && cdb_valid && (cdb_tag == in_src2_tag);

    assign in_fire    = in_valid && in_ready;
    assign issue_fire = issue_valid && issue_ready;
    assign in_ready   = |empty_vec;
    assign issue_valid = |issue_sel;

    always_comb
    begin
        free_sel  = '0;
        issue_sel = '0;
        issue_op  = issue_pkg::ALU_ADD;
        issue_a   = '0;
        issue_b   = '0;
        issue_tag = '0;
        issue_rob = '0;
        for (int i = DEPTH - 1; i >= 0; i--)    // downward scan, lowest hit wins
        begin
            empty_vec[i] = (state[i] == issue_pkg::EMPTY);
            wake1[i] = cdb_valid && !src1_ready[i] && (src1_tag[i] == cdb_tag);
            wake2[i] = cdb_valid && !src2_ready[i] && (src2_tag[i] == cdb_tag);
            if (empty_vec[i])
            begin
                free_sel = '0;
                free_sel[i] = 1'b1;
            end
            if (state[i] == issue_pkg::READY)
            begin
                issue_sel = '0;
                issue_sel[i] = 1'b1;
                issue_op  = op[i];
                issue_a   = src1_value[i];
                issue_b   = src2_value[i];
                issue_tag = dest_tag[i];
                issue_rob = rob[i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                state[i] <= issue_pkg::EMPTY;
            end
        end
        else
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                if (issue_fire && issue_sel[i])
                    state[i] <= issue_pkg::EMPTY;
                else if (in_fire && free_sel[i])
                    state[i] <= ((in_src1_ready || fwd1) && (in_src2_ready || fwd2)) ?
                                issue_pkg::READY : issue_pkg::WAITING;
                else if (state[i] == issue_pkg::WAITING &&
                         (src1_ready[i] || wake1[i]) && (src2_ready[i] || wake2[i]))
                    state[i] <= issue_pkg::READY;   // woken by this cycle's broadcast
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            if (in_fire && free_sel[i])
            begin
                op[i]         <= in_op;
                src1_tag[i]   <= in_src1_tag;
                src2_tag[i]   <= in_src2_tag;
                src1_ready[i] <= in_src1_ready || fwd1;
                src2_ready[i] <= in_src2_ready || fwd2;
                src1_value[i] <= fwd1 ? cdb_value : in_src1_value;
                src2_value[i] <= fwd2 ? cdb_value : in_src2_value;
                dest_tag[i]   <= in_dest_tag;
                rob[i]        <= in_rob;
            end
            else if (state[i] == issue_pkg::WAITING)
            begin
                if (wake1[i])
                begin
                    src1_ready[i] <= 1'b1;
                    src1_value[i] <= cdb_value;
                end
                if (wake2[i])
                begin
                    src2_ready[i] <= 1'b1;
                    src2_value[i] <= cdb_value;
                end
            end
        end
    end

    // an occupied entry keeps its identity until it issues
    for (genvar g = 0; g < DEPTH; g++)
    begin : g_entry_chk
        a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
            state[g] != issue_pkg::EMPTY && !(issue_fire && issue_sel[g]) |=>
                $stable(rob[g]) && $stable(dest_tag[g]) && $stable(op[g]));
    end

    a_issue_hold: assert property (@(posedge clk) disable iff (rst)
        issue_valid && !issue_ready |=> issue_valid);

endmodule

// File: issue_pkg.sv
package issue_pkg;

    localparam int DATA_W = 32;
    localparam int TAG_W  = 6;                  // physical register tag
    localparam int ROB_W  = 5;                  // reorder buffer index

    localparam int ADD_RS_DEPTH = 4;            // entries in the add/sub station
    localparam int MUL_RS_DEPTH = 2;            // entries in the multiply station
    localparam int MUL_STAGES   = 3;            // multiplier pipeline depth, at least 2

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [ROB_W-1:0]  rob_id_t;

    typedef enum logic [1:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL                                 // steered to the multiply station
    } alu_op_t;

    // life of one station entry
    typedef enum logic [1:0]
    {
        EMPTY,
        WAITING,                                // at least one source outstanding
        READY
    } rs_state_t;

endpackage
